//--- isq_consts.svh
// issue queue sizing constants shared by the package, the RTL and the testbench
`ifndef ISQ_CONSTS_SVH
`define ISQ_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// queue geometry
////////////////////////////////////////////////////////////////////////////

// total number of queue lines
`define ISQ_DEPTH      64
// log2 of the depth, width of a line index
`define ISQ_IDX_BITS   6
// dispatch slots per cycle, also the lines in one group
`define ISQ_INST_PORT  4
// log2(depth / slots), width of the group pointer
`define ISQ_GRP_BITS   4

////////////////////////////////////////////////////////////////////////////
// operand tags
////////////////////////////////////////////////////////////////////////////

// physical result tag width, as seen on the wakeup bus
`define ISQ_TAG_BITS   6

`endif

//--- isq_pkg.sv
// issue queue types: opcode encoding, dispatched instruction and issue record
`include "isq_consts.svh"

package isq_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // opcodes
   ////////////////////////////////////////////////////////////////////////////

   // 3 bit encoding, codes 5..7 unused
   typedef enum logic [2:0]
   {
      OP_ALU    = 3'd0,
      OP_MUL    = 3'd1,
      OP_LOAD   = 3'd2,
      OP_STORE  = 3'd3,
      OP_BRANCH = 3'd4
   } isq_op_e;

   ////////////////////////////////////////////////////////////////////////////
   // payloads
   ////////////////////////////////////////////////////////////////////////////

   // one instruction as held in a queue line, 23 bits
   typedef struct packed
   {
      isq_op_e                 op;
      logic [`ISQ_TAG_BITS-1:0] dst_tag;
      logic [`ISQ_TAG_BITS-1:0] src1_tag;
      logic [`ISQ_TAG_BITS-1:0] src2_tag;
      logic                    src1_rdy;
      logic                    src2_rdy;
   } isq_inst_t;

   // issued instruction with its line index, 30 bits
   typedef struct packed
   {
      logic                     vld;
      logic [`ISQ_IDX_BITS-1:0] idx;
      isq_inst_t                inst;
   } isq_issue_t;

endpackage

//--- isq_line_counter.sv
// issue queue line counter: group write pointer with flush load and line write enables
`timescale 1ns/1ps
`include "isq_consts.svh"

module isq_line_counter
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      set,
   input  logic [`ISQ_IDX_BITS-1:0]  val,
   input  logic [`ISQ_INST_PORT-1:0] inst_vld,
   input  logic                      isq_ful,
   output logic [`ISQ_DEPTH-1:0]     isq_lin_en,
   output logic [`ISQ_GRP_BITS-1:0]  counter
);

   // a bundle is taken when it has a real slot, there is room and no flush
   logic                                  cnt_en;
   // flush index rounded up to a group boundary
   logic [`ISQ_GRP_BITS-1:0]              set_grp;
   // one-hot group select, zero when nothing is written
   logic [`ISQ_DEPTH/`ISQ_INST_PORT-1:0]  grp_dec;

   assign cnt_en = (|inst_vld) & ~isq_ful & ~set;

   // upper bits give the group, any nonzero low bit bumps it by one
   // group 16 wraps back to 0
   assign set_grp = val[`ISQ_IDX_BITS-1 -: `ISQ_GRP_BITS]
                    + `ISQ_GRP_BITS'(|val[`ISQ_IDX_BITS-`ISQ_GRP_BITS-1:0]);

   ////////////////////////////////////////////////////////////////////////////
   // group pointer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         counter <= '0;
      else if (set)
         counter <= set_grp;
      else if (cnt_en)
         counter <= counter + 1'b1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // pointer decode and expansion to per-line write enables
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int g = 0; g < `ISQ_DEPTH/`ISQ_INST_PORT; g++)
         grp_dec[g] = cnt_en && (counter == `ISQ_GRP_BITS'(g));
   end

   // every line of the selected group is enabled, slot s goes to line 4g+s
   for (genvar g = 0; g < `ISQ_DEPTH/`ISQ_INST_PORT; g++)
   begin : g_lin_en
      assign isq_lin_en[g*`ISQ_INST_PORT +: `ISQ_INST_PORT] = {`ISQ_INST_PORT{grp_dec[g]}};
   end

endmodule

//--- isq_entry_array.sv
// issue queue entry array: line valids and payloads, wakeup, flush, full and ready vector
`timescale 1ns/1ps
`include "isq_consts.svh"

module isq_entry_array
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic [`ISQ_DEPTH-1:0]                      isq_lin_en,
   input  logic [`ISQ_INST_PORT-1:0]                  disp_vld,
   input  isq_pkg::isq_inst_t [`ISQ_INST_PORT-1:0]    disp_inst,
   input  logic [`ISQ_GRP_BITS-1:0]                   alloc_grp,
   input  logic                                       wakeup_vld,
   input  logic [`ISQ_TAG_BITS-1:0]                   wakeup_tag,
   input  logic                                       flush,
   input  logic [`ISQ_IDX_BITS-1:0]                   flush_idx,
   input  logic [`ISQ_DEPTH-1:0]                      issue_clr,
   output logic                                       isq_ful,
   output logic [`ISQ_DEPTH-1:0]                      line_rdy,
   output isq_pkg::isq_inst_t [`ISQ_DEPTH-1:0]        line_inst
);

   import isq_pkg::*;

   // valid bit per line
   logic [`ISQ_DEPTH-1:0]            line_vld;
   // stored instruction per line, ready bits included
   isq_inst_t [`ISQ_DEPTH-1:0]       line_q;
   // lines at or above the flush index
   logic [`ISQ_DEPTH-1:0]            flush_hit;
   // valid bits of the group under the pointer
   logic [`ISQ_INST_PORT-1:0]        grp_vld;

   ////////////////////////////////////////////////////////////////////////////
   // wakeup compare
   ////////////////////////////////////////////////////////////////////////////

   // sets the ready bit of every source whose tag matches the broadcast
   function automatic isq_inst_t wake_srcs
   (
      input isq_inst_t                inst,
      input logic                     bc_vld,
      input logic [`ISQ_TAG_BITS-1:0] bc_tag
   );
      isq_inst_t res;
      res = inst;
      if (bc_vld && (inst.src1_tag == bc_tag))
         res.src1_rdy = 1'b1;
      if (bc_vld && (inst.src2_tag == bc_tag))
         res.src2_rdy = 1'b1;
      return res;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // flush range
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
         flush_hit[i] = flush && (`ISQ_IDX_BITS'(i) >= flush_idx);
   end

   ////////////////////////////////////////////////////////////////////////////
   // valid bits
   ////////////////////////////////////////////////////////////////////////////

   // priority: flush, then dispatch write, then issue clear
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         line_vld <= '0;
      end
      else
      begin
         for (int i = 0; i < `ISQ_DEPTH; i++)
         begin
            if (flush_hit[i])
               line_vld[i] <= 1'b0;
            else if (isq_lin_en[i])
               // nop slots leave the line invalid
               line_vld[i] <= disp_vld[i % `ISQ_INST_PORT];
            else if (issue_clr[i])
               line_vld[i] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payload
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (isq_lin_en[i])
            // incoming sources see the same-edge broadcast too
            line_q[i] <= wake_srcs(disp_inst[i % `ISQ_INST_PORT], wakeup_vld, wakeup_tag);
         else if (line_vld[i])
            line_q[i] <= wake_srcs(line_q[i], wakeup_vld, wakeup_tag);
      end
   end

   assign line_inst = line_q;

   ////////////////////////////////////////////////////////////////////////////
   // full and ready
   ////////////////////////////////////////////////////////////////////////////

   // full as long as any line of the next group is still waiting
   assign grp_vld = line_vld[alloc_grp*`ISQ_INST_PORT +: `ISQ_INST_PORT];
   assign isq_ful = |grp_vld;

   // nothing is offered to the select while a flush is applied
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
         line_rdy[i] = line_vld[i] & line_q[i].src1_rdy & line_q[i].src2_rdy & ~flush;
   end

endmodule

//--- isq_issue_select.sv
// issue select that picks the lowest ready line, registers it for issue and clears it
`timescale 1ns/1ps
`include "isq_consts.svh"

module isq_issue_select
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [`ISQ_DEPTH-1:0]                line_rdy,
   input  isq_pkg::isq_inst_t [`ISQ_DEPTH-1:0]  line_inst,
   output logic [`ISQ_DEPTH-1:0]                issue_clr,
   output isq_pkg::isq_issue_t                  issue
);

   import isq_pkg::*;

   // any ready line this cycle
   logic                     pick_vld;
   // encoded position of the lowest ready line
   logic [`ISQ_IDX_BITS-1:0] pick_idx;
   // registered issue fields
   logic                     iss_vld_q;
   logic [`ISQ_IDX_BITS-1:0] iss_idx_q;
   isq_inst_t                iss_inst_q;

   ////////////////////////////////////////////////////////////////////////////
   // priority pick
   ////////////////////////////////////////////////////////////////////////////

   // lowest set bit of the ready vector as a one-hot clear
   assign issue_clr = line_rdy & (~line_rdy + 1'b1);
   assign pick_vld  = |line_rdy;

   // scan from the top so the lowest index is the last one written
   always_comb
   begin
      pick_idx = '0;
      for (int i = `ISQ_DEPTH-1; i >= 0; i--)
      begin
         if (line_rdy[i])
            pick_idx = `ISQ_IDX_BITS'(i);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // issue register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         iss_vld_q <= 1'b0;
      else
         iss_vld_q <= pick_vld;
   end

   // index and payload of the picked line
   always_ff @(posedge clk)
   begin
      if (pick_vld)
      begin
         iss_idx_q  <= pick_idx;
         iss_inst_q <= line_inst[pick_idx];
      end
   end

   assign issue.vld  = iss_vld_q;
   assign issue.idx  = iss_idx_q;
   assign issue.inst = iss_inst_q;

endmodule

//--- isq_top.sv
// issue queue top: dispatch allocation, entry array with wakeup and single issue select
`timescale 1ns/1ps
`include "isq_consts.svh"

module isq_top
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   // dispatch bundle, one valid per slot
   input  logic [`ISQ_INST_PORT-1:0]                disp_vld,
   input  isq_pkg::isq_inst_t [`ISQ_INST_PORT-1:0]  disp_inst,
   // result tag broadcast
   input  logic                                     wakeup_vld,
   input  logic [`ISQ_TAG_BITS-1:0]                 wakeup_tag,
   // flush of every line at or above flush_idx
   input  logic                                     flush,
   input  logic [`ISQ_IDX_BITS-1:0]                 flush_idx,
   output logic                                     isq_ful,
   output logic [`ISQ_GRP_BITS-1:0]                 alloc_grp,
   output isq_pkg::isq_issue_t                      issue
);

   import isq_pkg::*;

   // per-line write enables from the pointer
   logic [`ISQ_DEPTH-1:0]       isq_lin_en;
   // ready vector into the select
   logic [`ISQ_DEPTH-1:0]       line_rdy;
   // stored payloads into the select
   isq_inst_t [`ISQ_DEPTH-1:0]  line_inst;
   // one-hot clear of the line being issued
   logic [`ISQ_DEPTH-1:0]       issue_clr;

   ////////////////////////////////////////////////////////////////////////////
   // allocation pointer
   ////////////////////////////////////////////////////////////////////////////

   isq_line_counter u_line_counter
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .set        (flush),
      .val        (flush_idx),
      .inst_vld   (disp_vld),
      .isq_ful    (isq_ful),
      .isq_lin_en (isq_lin_en),
      .counter    (alloc_grp)
   );

   ////////////////////////////////////////////////////////////////////////////
   // lines and select
   ////////////////////////////////////////////////////////////////////////////

   isq_entry_array u_entry_array
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .isq_lin_en (isq_lin_en),
      .disp_vld   (disp_vld),
      .disp_inst  (disp_inst),
      .alloc_grp  (alloc_grp),
      .wakeup_vld (wakeup_vld),
      .wakeup_tag (wakeup_tag),
      .flush      (flush),
      .flush_idx  (flush_idx),
      .issue_clr  (issue_clr),
      .isq_ful    (isq_ful),
      .line_rdy   (line_rdy),
      .line_inst  (line_inst)
   );

   isq_issue_select u_issue_select
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .line_rdy  (line_rdy),
      .line_inst (line_inst),
      .issue_clr (issue_clr),
      .issue     (issue)
   );

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source, 20 ns clock with reset held low for 8 cycles
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   // 10 ns half period
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reset released on a rising edge so no flop sees it change mid-cycle
   initial
   begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- isq_tb.sv
// issue queue testbench running directed dispatch, wakeup, full and flush tests on a line model
`timescale 1ns/1ps
`include "isq_consts.svh"

module isq_tb;

   import isq_pkg::*;

   typedef isq_inst_t [`ISQ_INST_PORT-1:0] bundle_t;

   // cycle budget of reset 10 dispatch 60 wakeup 40 full 90 and flush 16 x 75
   localparam int TEST_CYCLES = 1400;
   localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 4;

   logic                       clk;
   logic                       rst_n;
   logic [`ISQ_INST_PORT-1:0]  disp_vld;
   bundle_t                    disp_inst;
   logic                       wakeup_vld;
   logic [`ISQ_TAG_BITS-1:0]   wakeup_tag;
   logic                       flush;
   logic [`ISQ_IDX_BITS-1:0]   flush_idx;
   logic                       isq_ful;
   logic [`ISQ_GRP_BITS-1:0]   alloc_grp;
   isq_issue_t                 issue;

   // model of the lines, the group pointer and the issue register
   logic [`ISQ_DEPTH-1:0]      m_vld;
   isq_inst_t                  m_inst [`ISQ_DEPTH];
   logic [`ISQ_GRP_BITS-1:0]   m_ptr;
   isq_issue_t                 m_iss;
   // DUT outputs as seen at the last falling edge
   logic                       smp_iss_vld;
   logic                       smp_ful;
   logic [`ISQ_GRP_BITS-1:0]   smp_grp;
   // issued line indices in order of issue
   int                         iss_log [$];
   logic [31:0]                lfsr_state = 32'h8f695cc6;
   int                         cycle_cnt = 0;

   tb_clk_gen u_clk_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   isq_top isq_top_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .disp_vld   (disp_vld),
      .disp_inst  (disp_inst),
      .wakeup_vld (wakeup_vld),
      .wakeup_tag (wakeup_tag),
      .flush      (flush),
      .flush_idx  (flush_idx),
      .isq_ful    (isq_ful),
      .alloc_grp  (alloc_grp),
      .issue      (issue)
   );

   ////////////////////////////////////////////////////////////////////////////
   // random bits and reporting
   ////////////////////////////////////////////////////////////////////////////

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   function automatic isq_inst_t rand_inst(input logic rdy1, input logic rdy2,
                                           input logic [`ISQ_TAG_BITS-1:0] tag1,
                                           input logic [`ISQ_TAG_BITS-1:0] tag2);
      isq_inst_t inst;
      inst.op       = isq_op_e'(take_bits(3) % 5);
      inst.dst_tag  = take_bits(`ISQ_TAG_BITS);
      inst.src1_tag = tag1;
      inst.src2_tag = tag2;
      inst.src1_rdy = rdy1;
      inst.src2_rdy = rdy2;
      return inst;
   endfunction

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   always @(posedge clk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT)
      begin
         $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // line model
   ////////////////////////////////////////////////////////////////////////////

   // group index of a flush point rounded up and wrapping past group 15
   function automatic logic [`ISQ_GRP_BITS-1:0] round_up_grp(input logic [`ISQ_IDX_BITS-1:0] idx);
      return `ISQ_GRP_BITS'((idx + `ISQ_INST_PORT - 1) / `ISQ_INST_PORT);
   endfunction

   function automatic logic model_full();
      return |m_vld[m_ptr*`ISQ_INST_PORT +: `ISQ_INST_PORT];
   endfunction

   function automatic logic model_any_ready();
      logic found;
      found = 1'b0;
      for (int i = 0; i < `ISQ_DEPTH; i++)
         found |= m_vld[i] & m_inst[i].src1_rdy & m_inst[i].src2_rdy;
      return found;
   endfunction

   // broadcast tag marks matching sources ready
   function automatic isq_inst_t apply_wakeup(input isq_inst_t inst);
      isq_inst_t woke;
      woke = inst;
      if (wakeup_vld && inst.src1_tag == wakeup_tag)
         woke.src1_rdy = 1'b1;
      if (wakeup_vld && inst.src2_tag == wakeup_tag)
         woke.src2_rdy = 1'b1;
      return woke;
   endfunction

   // advance the model across one rising edge with the inputs now applied
   task automatic model_step();
      int   pick;
      logic take;
      pick = -1;
      for (int i = `ISQ_DEPTH-1; i >= 0; i--)
         if (m_vld[i] && m_inst[i].src1_rdy && m_inst[i].src2_rdy && !flush)
            pick = i;
      take = (disp_vld != '0) && !model_full() && !flush;
      m_iss.vld = (pick >= 0);
      if (pick >= 0)
      begin
         m_iss.idx  = `ISQ_IDX_BITS'(pick);
         m_iss.inst = m_inst[pick];
      end
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (flush && i >= flush_idx)
            m_vld[i] = 1'b0;
         else if (take && i / `ISQ_INST_PORT == m_ptr)
         begin
            m_vld[i]  = disp_vld[i % `ISQ_INST_PORT];
            m_inst[i] = apply_wakeup(disp_inst[i % `ISQ_INST_PORT]);
         end
         else if (i == pick)
            m_vld[i] = 1'b0;
         else if (m_vld[i])
            m_inst[i] = apply_wakeup(m_inst[i]);
      end
      if (flush)
         m_ptr = round_up_grp(flush_idx);
      else if (take)
         m_ptr = m_ptr + 1'b1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // cycle handling
   ////////////////////////////////////////////////////////////////////////////

   // compare at the falling edge and step the model before the rising edge
   task automatic tick();
      @(negedge clk);
      smp_iss_vld = issue.vld;
      smp_ful     = isq_ful;
      smp_grp     = alloc_grp;
      check_val("issue.vld", issue.vld, m_iss.vld);
      if (m_iss.vld)
      begin
         check_val("issue.idx", issue.idx, m_iss.idx);
         check_val("issue.inst", issue.inst, m_iss.inst);
         iss_log.push_back(issue.idx);
      end
      check_val("isq_ful", isq_ful, model_full());
      check_val("alloc_grp", alloc_grp, m_ptr);
      model_step();
      @(posedge clk);
   endtask

   task automatic drive_idle();
      disp_vld   <= '0;
      disp_inst  <= '0;
      wakeup_vld <= 1'b0;
      wakeup_tag <= '0;
      flush      <= 1'b0;
      flush_idx  <= '0;
   endtask

   task automatic drive_bundle(input logic [`ISQ_INST_PORT-1:0] vld, input bundle_t bnd);
      disp_vld  <= vld;
      disp_inst <= bnd;
   endtask

   // flush at index 0 empties every line and parks the pointer on group 0
   task automatic flush_at(input logic [`ISQ_IDX_BITS-1:0] idx);
      flush     <= 1'b1;
      flush_idx <= idx;
      tick();
      drive_idle();
      tick();
   endtask

   // idle until no line is ready and no issue is pending
   task automatic wait_issue_idle(input int limit);
      int n;
      n = 0;
      drive_idle();
      tick();
      while ((model_any_ready() || m_iss.vld || smp_iss_vld) && n < limit)
      begin
         tick();
         n++;
      end
      if (n >= limit)
      begin
         $display("issue queue did not drain within %0d cycles", limit);
         abort_run();
      end
   endtask

   task automatic check_ascending();
      for (int k = 1; k < iss_log.size(); k++)
         check_val("issue order", iss_log[k] > iss_log[k-1], 1'b1);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_state();
      drive_idle();
      repeat (6)
      begin
         tick();
         check_val("issue.vld", smp_iss_vld, 1'b0);
         check_val("isq_ful", smp_ful, 1'b0);
         check_val("alloc_grp", smp_grp, '0);
      end
   endtask

   // bundle 3 carries nop slots only and must not move the pointer
   task automatic dispatch_order();
      bundle_t                   bnd;
      logic [`ISQ_INST_PORT-1:0] vld;
      logic [`ISQ_GRP_BITS-1:0]  grp_before;
      int                        n_valid;
      iss_log.delete();
      n_valid = 0;
      for (int b = 0; b < 8; b++)
      begin
         vld = take_bits(`ISQ_INST_PORT);
         if (b == 0)
            vld = '1;
         if (b == 3)
            vld = '0;
         for (int s = 0; s < `ISQ_INST_PORT; s++)
         begin
            bnd[s] = rand_inst(1'b1, 1'b1, take_bits(6), '0);
            bnd[s].src2_tag = take_bits(6);
            n_valid += vld[s];
         end
         grp_before = m_ptr;
         drive_bundle(vld, bnd);
         tick();
         drive_idle();
         tick();
         check_val("alloc_grp step", smp_grp, `ISQ_GRP_BITS'(grp_before + (vld != '0)));
      end
      wait_issue_idle(64);
      check_val("issue count", iss_log.size(), n_valid);
      check_ascending();
   endtask

   task automatic wakeup_sources();
      bundle_t                  bnd;
      logic [`ISQ_TAG_BITS-1:0] t1;
      logic [`ISQ_TAG_BITS-1:0] t2;
      logic [`ISQ_TAG_BITS-1:0] t3;
      int                       base;
      t1 = take_bits(`ISQ_TAG_BITS);
      t2 = t1 + 1'b1;
      t3 = t1 + 2'd2;
      base = m_ptr * `ISQ_INST_PORT;
      bnd[0] = rand_inst(1'b0, 1'b0, t1, t2);
      bnd[1] = rand_inst(1'b0, 1'b0, t2, t1);
      bnd[2] = rand_inst(1'b1, 1'b1, t3, t3);
      bnd[3] = rand_inst(1'b0, 1'b0, t1, t2);
      iss_log.delete();
      // slot 2 is a nop
      drive_bundle(4'b1011, bnd);
      tick();
      drive_idle();
      tick();
      wakeup_vld <= 1'b1;
      wakeup_tag <= t1;
      tick();
      drive_idle();
      repeat (4) tick();
      check_val("issues after one wakeup", iss_log.size(), 0);
      wakeup_vld <= 1'b1;
      wakeup_tag <= t2;
      tick();
      wait_issue_idle(16);
      check_val("issues after both wakeups", iss_log.size(), 3);
      check_val("first issue", iss_log[0], base);
      check_val("second issue", iss_log[1], base + 1);
      check_val("third issue", iss_log[2], base + 3);
      // broadcast on the dispatch edge itself
      base = m_ptr * `ISQ_INST_PORT;
      bnd[0] = rand_inst(1'b0, 1'b1, t3, t1);
      iss_log.delete();
      drive_bundle(4'b0001, bnd);
      wakeup_vld <= 1'b1;
      wakeup_tag <= t3;
      tick();
      wait_issue_idle(16);
      check_val("same edge wakeup issues", iss_log.size(), 1);
      check_val("same edge wakeup line", iss_log[0], base);
   endtask

   // group g waits on tag 16+g for both sources
   task automatic full_backpressure();
      bundle_t bnd;
      int      n;
      flush_at('0);
      for (int g = 0; g < `ISQ_DEPTH / `ISQ_INST_PORT; g++)
      begin
         for (int s = 0; s < `ISQ_INST_PORT; s++)
            bnd[s] = rand_inst(1'b0, 1'b0, 6'd16 + g, 6'd16 + g);
         drive_bundle('1, bnd);
         tick();
      end
      for (int s = 0; s < `ISQ_INST_PORT; s++)
         bnd[s] = rand_inst(1'b1, 1'b1, take_bits(6), '0);
      iss_log.delete();
      // bundle held while the queue is full
      drive_bundle('1, bnd);
      repeat (5)
      begin
         tick();
         check_val("isq_ful while held", smp_ful, 1'b1);
         check_val("alloc_grp while held", smp_grp, '0);
      end
      wakeup_vld <= 1'b1;
      wakeup_tag <= 6'd16;
      tick();
      wakeup_vld <= 1'b0;
      n = 0;
      while (smp_grp == '0 && n < 20)
      begin
         tick();
         n++;
      end
      if (n >= 20)
      begin
         $display("held bundle was never accepted after group 0 drained");
         abort_run();
      end
      check_val("alloc_grp after accept", smp_grp, 1);
      check_val("group 0 issues", iss_log.size(), `ISQ_INST_PORT);
      for (int s = 0; s < `ISQ_INST_PORT; s++)
         check_val("group 0 issue line", iss_log[s], s);
      wait_issue_idle(20);
   endtask

   // every fill waits on tag 40 which is broadcast after the flush
   task automatic flush_ranges();
      bundle_t                   bnd;
      logic [`ISQ_INST_PORT-1:0] vld;
      logic [`ISQ_IDX_BITS-1:0]  fidx;
      int                        grp;
      int                        exp_cnt;
      for (int r = 0; r < 16; r++)
      begin
         flush_at('0);
         fidx = take_bits(`ISQ_IDX_BITS);
         grp = 0;
         exp_cnt = 0;
         for (int b = 0; b < 10; b++)
         begin
            vld = take_bits(`ISQ_INST_PORT);
            for (int s = 0; s < `ISQ_INST_PORT; s++)
            begin
               bnd[s] = rand_inst(1'b0, 1'b0, 6'd40, 6'd40);
               if (vld[s] && grp * `ISQ_INST_PORT + s < fidx)
                  exp_cnt++;
            end
            grp += (vld != '0);
            drive_bundle(vld, bnd);
            tick();
         end
         drive_idle();
         flush_at(fidx);
         check_val("alloc_grp after flush", smp_grp, round_up_grp(fidx));
         iss_log.delete();
         wakeup_vld <= 1'b1;
         wakeup_tag <= 6'd40;
         tick();
         wait_issue_idle(80);
         check_val("issues below flush index", iss_log.size(), exp_cnt);
         foreach (iss_log[k])
            check_val("issued line below flush index", iss_log[k] < fidx, 1'b1);
         // next bundle lands at the reloaded pointer
         for (int s = 0; s < `ISQ_INST_PORT; s++)
            bnd[s] = rand_inst(1'b1, 1'b1, take_bits(6), take_bits(6));
         iss_log.delete();
         drive_bundle('1, bnd);
         tick();
         drive_idle();
         tick();
         check_val("alloc_grp after refill", smp_grp, `ISQ_GRP_BITS'(round_up_grp(fidx) + 1));
         wait_issue_idle(20);
         check_val("refill issues", iss_log.size(), `ISQ_INST_PORT);
         for (int s = 0; s < `ISQ_INST_PORT; s++)
            check_val("refill line", iss_log[s], round_up_grp(fidx) * `ISQ_INST_PORT + s);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      disp_vld   = '0;
      disp_inst  = '0;
      wakeup_vld = 1'b0;
      wakeup_tag = '0;
      flush      = 1'b0;
      flush_idx  = '0;
      m_vld      = '0;
      m_ptr      = '0;
      m_iss      = '0;
      for (int i = 0; i < `ISQ_DEPTH; i++)
         m_inst[i] = '0;
      wait (rst_n === 1'b1);
      @(posedge clk);
      reset_state();
      dispatch_order();
      wakeup_sources();
      full_backpressure();
      flush_ranges();
      $display("test passed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
isq_pkg.sv
isq_line_counter.sv
isq_entry_array.sv
isq_issue_select.sv
isq_top.sv
tb_clk_gen.sv
isq_tb.sv
